// ==== design/soundPkg.sv ====
`default_nettype none

package soundPkg;

	////////////////////
	// Widths with a meaning
	typedef logic [3:0]  regAddrT;   // Register file address
	typedef logic [7:0]  regDataT;   // CPU write data
	typedef logic [10:0] freqT;      // Channel frequency code
	typedef logic [3:0]  volumeT;    // Envelope volume 0..15
	typedef logic [4:0]  levelT;     // Channel output level 0..30
	typedef logic [8:0]  sampleT;    // Mixed and scaled sample

	// Eight-step duty patterns
	typedef enum logic [1:0] {
		duty12 = 2'd0,   // High on step 7
		duty25 = 2'd1,   // Steps 0 and 7
		duty50 = 2'd2,   // Steps 0, 5, 6, 7
		duty75 = 2'd3    // Steps 1 to 6
	} dutyT;

	////////////////////
	// Register map, channel 1 at 0..3 and channel 2 at 4..7
	localparam regAddrT AddrDuty1   = 4'd0;
	localparam regAddrT AddrEnv1    = 4'd1;
	localparam regAddrT AddrFreqLo1 = 4'd2;
	localparam regAddrT AddrFreqHi1 = 4'd3;   // Bit 7 triggers, bit 6 timed mode
	localparam regAddrT AddrDuty2   = 4'd4;
	localparam regAddrT AddrEnv2    = 4'd5;
	localparam regAddrT AddrFreqLo2 = 4'd6;
	localparam regAddrT AddrFreqHi2 = 4'd7;
	localparam regAddrT AddrMaster  = 4'd8;   // Master volume in bits 2:0
	localparam regAddrT AddrEnable  = 4'd9;   // Channel enable mask in bits 1:0

	////////////////////
	// Dividers and constants
	localparam int ToneDivide      = 4;      // Clocks per tone tick
	localparam int FrameDivide     = 8192;   // Clocks per frame step, 512 Hz at 4 MHz
	localparam int ToneCountWidth  = $clog2(ToneDivide);
	localparam int FrameCountWidth = $clog2(FrameDivide);
	localparam levelT LevelMid     = 5'd15;  // Silent level
	localparam int NumChannels     = 2;

endpackage

`default_nettype wire

// ==== design/frameSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module frameSequencer import soundPkg::*; (
	input  wire  iClock,
	input  wire  arstN,
	output logic toneTick,       // One cycle every ToneDivide clocks
	output logic lengthTick,     // 256 Hz, entering an even step
	output logic envelopeTick    // 64 Hz, entering step 7
);

	logic [ToneCountWidth-1:0]  toneCount;
	logic [FrameCountWidth-1:0] frameCount;
	logic [2:0]                 frameStep;
	logic [2:0]                 nextStep;
	logic                       frameWrap;

	assign frameWrap = (frameCount == FrameCountWidth'(FrameDivide - 1));
	assign nextStep  = frameStep + 3'd1;   // Wraps 7 -> 0

	////////////////////
	// Tone divider
	always_ff @(posedge iClock or negedge arstN) begin
		if (!arstN) begin
			toneCount <= '0;
			toneTick  <= 1'b0;
		end else begin
			if (toneCount == ToneCountWidth'(ToneDivide - 1))
				toneCount <= '0;
			else
				toneCount <= toneCount + 1'b1;
			toneTick <= (toneCount == ToneCountWidth'(ToneDivide - 1));
		end
	end

	////////////////////
	// Frame divider and step decode
	always_ff @(posedge iClock or negedge arstN) begin
		if (!arstN) begin
			frameCount   <= '0;
			frameStep    <= '0;
			lengthTick   <= 1'b0;
			envelopeTick <= 1'b0;
		end else begin
			frameCount <= frameWrap ? '0 : frameCount + 1'b1;
			if (frameWrap)
				frameStep <= nextStep;
			// Ticks rise together with the step they belong to
			lengthTick   <= frameWrap && !nextStep[0];
			envelopeTick <= frameWrap && (nextStep == 3'd7);
		end
	end

endmodule

`default_nettype wire

// ==== design/soundRegisters.sv ====
`timescale 1ns/100ps
`default_nettype none

module soundRegisters import soundPkg::*; (
	input  wire                          iClock,
	input  wire                          arstN,
	input  wire                          wrEnable,
	input  wire regAddrT                 wrAddr,
	input  wire regDataT                 wrData,
	output logic                         trigger1,
	output logic                         trigger2,
	output dutyT                         duty1,
	output logic [5:0]                   lengthLoad1,
	output volumeT                       envelopeInit1,
	output logic                         envelopeUp1,
	output logic [2:0]                   envelopePeriod1,
	output freqT                         frequency1,
	output logic                         timedMode1,
	output dutyT                         duty2,
	output logic [5:0]                   lengthLoad2,
	output volumeT                       envelopeInit2,
	output logic                         envelopeUp2,
	output logic [2:0]                   envelopePeriod2,
	output freqT                         frequency2,
	output logic                         timedMode2,
	output logic [2:0]                   masterVolume,
	output logic [NumChannels-1:0]       enableMask
);

	always_ff @(posedge iClock or negedge arstN) begin
		if (!arstN) begin
			{duty1, lengthLoad1}                             <= '0;
			{envelopeInit1, envelopeUp1, envelopePeriod1}    <= '0;
			{frequency1, timedMode1}                         <= '0;
			{duty2, lengthLoad2}                             <= '0;
			{envelopeInit2, envelopeUp2, envelopePeriod2}    <= '0;
			{frequency2, timedMode2}                         <= '0;
			masterVolume <= '0;
			enableMask   <= '0;
			trigger1     <= 1'b0;
			trigger2     <= 1'b0;
		end else begin
			// Trigger lands one cycle after the write, fields already settled
			trigger1 <= wrEnable && (wrAddr == AddrFreqHi1) && wrData[7];
			trigger2 <= wrEnable && (wrAddr == AddrFreqHi2) && wrData[7];
			if (wrEnable) begin
				unique case (wrAddr)
					AddrDuty1:   {duty1, lengthLoad1} <= {dutyT'(wrData[7:6]), wrData[5:0]};
					AddrEnv1:    {envelopeInit1, envelopeUp1, envelopePeriod1} <= wrData;
					AddrFreqLo1: frequency1[7:0] <= wrData;
					AddrFreqHi1: begin
						timedMode1       <= wrData[6];
						frequency1[10:8] <= wrData[2:0];   // Bit 7 is not kept
					end
					AddrDuty2:   {duty2, lengthLoad2} <= {dutyT'(wrData[7:6]), wrData[5:0]};
					AddrEnv2:    {envelopeInit2, envelopeUp2, envelopePeriod2} <= wrData;
					AddrFreqLo2: frequency2[7:0] <= wrData;
					AddrFreqHi2: begin
						timedMode2       <= wrData[6];
						frequency2[10:8] <= wrData[2:0];
					end
					AddrMaster:  masterVolume <= wrData[2:0];
					AddrEnable:  enableMask   <= wrData[NumChannels-1:0];
					default:     ;   // Unmapped, write ignored
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/squareChannel.sv ====
`timescale 1ns/100ps
`default_nettype none

module squareChannel import soundPkg::*; (
	input  wire         iClock,
	input  wire         arstN,
	input  wire         toneTick,
	input  wire         lengthTick,
	input  wire         envelopeTick,
	input  wire         trigger,         // One-cycle restart
	input  wire dutyT   duty,
	input  wire [5:0]   lengthLoad,
	input  wire volumeT envelopeInit,
	input  wire         envelopeUp,
	input  wire [2:0]   envelopePeriod,  // 0 freezes the volume
	input  wire freqT   frequency,
	input  wire         timedMode,
	output levelT       level,
	output logic        active
);

	freqT       freqCount;     // Tone ticks left in this duty step
	logic [2:0] dutyStep;
	logic [6:0] lengthCount;   // 1..64 after trigger
	logic [2:0] envCount;      // Envelope ticks left until next volume step
	volumeT     volume;
	logic       patternBit;

	////////////////////
	// Duty pattern lookup
	always_comb begin
		unique case (duty)
			duty12:  patternBit = (dutyStep == 3'd7);
			duty25:  patternBit = (dutyStep == 3'd0) || (dutyStep == 3'd7);
			duty50:  patternBit = (dutyStep == 3'd0) || (dutyStep >= 3'd5);
			duty75:  patternBit = (dutyStep != 3'd0) && (dutyStep != 3'd7);
			default: patternBit = 1'b0;
		endcase
	end

	////////////////////
	// Frequency timer and duty step
	always_ff @(posedge iClock or negedge arstN) begin
		if (!arstN) begin
			freqCount <= '0;
			dutyStep  <= '0;
		end else if (trigger) begin
			freqCount <= ~frequency;   // 2047 - f, so 2048 - f ticks per step
			dutyStep  <= '0;
		end else if (toneTick) begin
			if (freqCount == '0) begin
				freqCount <= ~frequency;   // Picks up a frequency change here
				dutyStep  <= dutyStep + 3'd1;
			end else begin
				freqCount <= freqCount - 1'b1;
			end
		end
	end

	////////////////////
	// Length timer and active flag
	always_ff @(posedge iClock or negedge arstN) begin
		if (!arstN) begin
			lengthCount <= '0;
			active      <= 1'b0;
		end else if (trigger) begin
			lengthCount <= 7'd64 - {1'b0, lengthLoad};
			active      <= 1'b1;
		end else if (lengthTick && active && timedMode) begin
			lengthCount <= lengthCount - 1'b1;
			if (lengthCount == 7'd1)
				active <= 1'b0;   // Expires on the same edge
		end
	end

	////////////////////
	// Volume envelope
	always_ff @(posedge iClock or negedge arstN) begin
		if (!arstN) begin
			envCount <= '0;
			volume   <= '0;
		end else if (trigger) begin
			envCount <= envelopePeriod;
			volume   <= envelopeInit;
		end else if (envelopeTick && active && (envelopePeriod != 3'd0)) begin
			if (envCount <= 3'd1) begin
				envCount <= envelopePeriod;   // Period done, step the volume
				if (envelopeUp && (volume != 4'hF))
					volume <= volume + 4'd1;
				else if (!envelopeUp && (volume != 4'h0))
					volume <= volume - 4'd1;
			end else begin
				envCount <= envCount - 3'd1;
			end
		end
	end

	// Output level around the midpoint, one cycle behind the state
	always_ff @(posedge iClock or negedge arstN) begin
		if (!arstN)
			level <= LevelMid;
		else if (!active)
			level <= LevelMid;   // Silent
		else if (patternBit)
			level <= LevelMid + levelT'(volume);
		else
			level <= LevelMid - levelT'(volume);
	end

endmodule

`default_nettype wire

// ==== design/soundMixer.sv ====
`timescale 1ns/100ps
`default_nettype none

module soundMixer import soundPkg::*; (
	input  wire                    iClock,
	input  wire                    arstN,
	input  wire levelT             level1,
	input  wire levelT             level2,
	input  wire [NumChannels-1:0]  enableMask,
	input  wire [2:0]              masterVolume,
	output sampleT                 sample
);

	levelT      masked1;
	levelT      masked2;
	logic [5:0] levelSum;   // Up to 60
	logic [3:0] scale;      // masterVolume + 1, 1..8
	logic [9:0] product;    // Up to 480

	////////////////////
	// Mask, add, scale
	assign masked1  = enableMask[0] ? level1 : '0;   // Disabled channel adds nothing
	assign masked2  = enableMask[1] ? level2 : '0;
	assign levelSum = {1'b0, masked1} + {1'b0, masked2};
	assign scale    = {1'b0, masterVolume} + 4'd1;
	assign product  = 10'(levelSum) * 10'(scale);

	// Divide by 8 and register, truncating
	always_ff @(posedge iClock or negedge arstN) begin
		if (!arstN)
			sample <= '0;
		else
			sample <= sampleT'(product >> 3);
	end

endmodule

`default_nettype wire

// ==== design/soundCtrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module soundCtrl import soundPkg::*; (
	input  wire          iClock,
	input  wire          arstN,
	input  wire          wrEnable,
	input  wire regAddrT wrAddr,
	input  wire regDataT wrData,
	output sampleT       sample,
	output logic         active1,
	output logic         active2
);

	logic toneTick, lengthTick, envelopeTick;
	logic trigger1, trigger2;
	dutyT duty1, duty2;
	logic [5:0] lengthLoad1, lengthLoad2;
	volumeT envelopeInit1, envelopeInit2;
	logic envelopeUp1, envelopeUp2;
	logic [2:0] envelopePeriod1, envelopePeriod2;
	freqT frequency1, frequency2;
	logic timedMode1, timedMode2;
	logic [2:0] masterVolume;
	logic [NumChannels-1:0] enableMask;
	levelT level1, level2;

	////////////////////
	// Ticks and CPU registers
	frameSequencer frameSeq (.iClock, .arstN, .toneTick, .lengthTick, .envelopeTick);

	soundRegisters regFile (.iClock, .arstN, .wrEnable, .wrAddr, .wrData,
		.trigger1, .trigger2,
		.duty1, .lengthLoad1, .envelopeInit1, .envelopeUp1, .envelopePeriod1,
		.frequency1, .timedMode1,
		.duty2, .lengthLoad2, .envelopeInit2, .envelopeUp2, .envelopePeriod2,
		.frequency2, .timedMode2,
		.masterVolume, .enableMask);

	////////////////////
	// Two square channels
	squareChannel channel1 (.iClock, .arstN, .toneTick, .lengthTick, .envelopeTick,
		.trigger(trigger1), .duty(duty1), .lengthLoad(lengthLoad1),
		.envelopeInit(envelopeInit1), .envelopeUp(envelopeUp1),
		.envelopePeriod(envelopePeriod1), .frequency(frequency1),
		.timedMode(timedMode1), .level(level1), .active(active1));

	squareChannel channel2 (.iClock, .arstN, .toneTick, .lengthTick, .envelopeTick,
		.trigger(trigger2), .duty(duty2), .lengthLoad(lengthLoad2),
		.envelopeInit(envelopeInit2), .envelopeUp(envelopeUp2),
		.envelopePeriod(envelopePeriod2), .frequency(frequency2),
		.timedMode(timedMode2), .level(level2), .active(active2));

	// Mix to the output sample
	soundMixer mixer (.iClock, .arstN, .level1, .level2, .enableMask, .masterVolume, .sample);

endmodule

`default_nettype wire

// ==== testbench/soundCtrl_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module soundCtrlAsserts import soundPkg::*; (
	input wire        iClock,
	input wire        arstN,
	input wire        toneTick,
	input wire        lengthTick,
	input wire        envelopeTick,
	input wire        trigger1,
	input wire        trigger2,
	input wire        active1,
	input wire        active2,
	input wire levelT level1,
	input wire levelT level2
);

	int failCount = 0;   // Failed assertions so far

	////////////////////
	// Ticks are single-cycle enables
	toneOneCycle: assert property (@(posedge iClock) disable iff (!arstN)
		toneTick |=> !toneTick) else begin
		failCount++;
		$error("toneTick high for more than one cycle");
	end
	lengthOneCycle: assert property (@(posedge iClock) disable iff (!arstN)
		lengthTick |=> !lengthTick) else begin
		failCount++;
		$error("lengthTick high for more than one cycle");
	end
	envOneCycle: assert property (@(posedge iClock) disable iff (!arstN)
		envelopeTick |=> !envelopeTick) else begin
		failCount++;
		$error("envelopeTick high for more than one cycle");
	end

	////////////////////
	// Trigger pulses
	trig1Pulse: assert property (@(posedge iClock) disable iff (!arstN)
		trigger1 |=> !trigger1) else begin
		failCount++;
		$error("trigger1 high on two cycles in a row");
	end
	trig2Pulse: assert property (@(posedge iClock) disable iff (!arstN)
		trigger2 |=> !trigger2) else begin
		failCount++;
		$error("trigger2 high on two cycles in a row");
	end

	// Silent level one cycle after an inactive state
	silent1: assert property (@(posedge iClock) disable iff (!arstN)
		!active1 |=> (level1 == LevelMid)) else begin
		failCount++;
		$error("channel 1 inactive but not silent");
	end
	silent2: assert property (@(posedge iClock) disable iff (!arstN)
		!active2 |=> (level2 == LevelMid)) else begin
		failCount++;
		$error("channel 2 inactive but not silent");
	end

	// Only a trigger starts a channel
	rise1: assert property (@(posedge iClock) disable iff (!arstN)
		$rose(active1) |-> $past(trigger1)) else begin
		failCount++;
		$error("active1 rose without trigger1");
	end
	rise2: assert property (@(posedge iClock) disable iff (!arstN)
		$rose(active2) |-> $past(trigger2)) else begin
		failCount++;
		$error("active2 rose without trigger2");
	end

endmodule

bind soundCtrl soundCtrlAsserts asserts (.*);

`default_nettype wire

// ==== testbench/soundCtrlTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module soundCtrlTb import soundPkg::*; ();

	localparam int NumRows = 8;
	localparam int Margin  = 16;   // Cycles kept clear of any transition

	typedef struct packed {
		logic [7:0]  dutyLen1;   // Duty in 7:6 and length load in 5:0
		logic [7:0]  env1;       // Init 7:4, up 3, period 2:0
		logic [10:0] freq1;
		logic        timed1;
		logic [7:0]  dutyLen2;
		logic [7:0]  env2;
		logic [10:0] freq2;
		logic        timed2;
		logic [1:0]  mask;
		logic [2:0]  master;
		int          cycles;     // Row length from the first write
		int          evAt;       // Offset of a channel 1 control write or 0
		logic [7:0]  evCtrl;
		logic        expAct1;
		logic        expAct2;
	} rowT;

	logic    iClock;
	logic    arstN;
	logic    wrEnable;
	regAddrT wrAddr;
	regDataT wrData;
	sampleT  sample;
	logic    active1;
	logic    active2;

	rowT rows [NumRows];
	int  cyc = 0;
	int  errors;
	int  checks;
	int  quietUntil;
	int  rowStart;

	// Model register shadow
	logic [7:0] rDutyLen [2];
	logic [7:0] rEnv [2];
	freqT       rFreq [2];
	logic       rTimed [2];
	logic [1:0] rMask;
	logic [2:0] rMaster;
	// Model channel state
	logic mActive [2];
	int   mStep [2];
	int   mStepStart [2];
	int   mStepLen [2];
	int   mLen [2];
	int   mVol [2];
	int   mEnvCnt [2];
	int   mLastK [2];   // Last frame boundary applied

	soundCtrl u_soundCtrl (.iClock, .arstN, .wrEnable, .wrAddr, .wrData,
		.sample, .active1, .active2);

	initial begin
		iClock = 1'b0;
		forever #50 iClock = ~iClock;
	end

	always @(posedge iClock)
		if (arstN)
			cyc <= cyc + 1;   // Edges since reset release

	////////////////////
	// Stimulus helpers
	task automatic step();
		@(posedge iClock);
		#10;
	endtask

	function automatic logic patternHigh(input logic [1:0] duty, input int stepIdx);
		logic [7:0] pattern;
		case (duty)
			2'd0:    pattern = 8'b1000_0000;
			2'd1:    pattern = 8'b1000_0001;
			2'd2:    pattern = 8'b1110_0001;
			default: pattern = 8'b0111_1110;
		endcase
		return pattern[3'(stepIdx)];
	endfunction

	task automatic startChannel(input int ch, input int tt);
		mActive[ch]    = 1'b1;
		mStep[ch]      = 0;
		mStepStart[ch] = tt;
		mStepLen[ch]   = 4 * (2048 - int'(rFreq[ch]));
		mLen[ch]       = 64 - int'(rDutyLen[ch][5:0]);
		mVol[ch]       = int'(rEnv[ch][7:4]);
		mEnvCnt[ch]    = int'(rEnv[ch][2:0]);
		mLastK[ch]     = tt / FrameDivide;
	endtask

	// Walk the model of one channel forward to edge e
	task automatic advance(input int ch, input int e);
		int period;
		while (e >= mStepStart[ch] + mStepLen[ch]) begin
			mStepStart[ch] += mStepLen[ch];
			mStep[ch]      = (mStep[ch] + 1) % 8;
			mStepLen[ch]   = 4 * (2048 - int'(rFreq[ch]));   // Reload takes the current code
		end
		while ((mLastK[ch] + 1) * FrameDivide <= e) begin
			mLastK[ch]++;
			period = int'(rEnv[ch][2:0]);
			if ((mLastK[ch] % 2 == 0) && mActive[ch] && rTimed[ch]) begin   // Length tick
				mLen[ch]--;
				if (mLen[ch] == 0)
					mActive[ch] = 1'b0;
			end
			if ((mLastK[ch] % 8 == 7) && mActive[ch] && (period != 0)) begin   // Envelope tick
				if (mEnvCnt[ch] <= 1) begin
					mEnvCnt[ch] = period;
					if (rEnv[ch][3] && mVol[ch] < 15)
						mVol[ch]++;
					else if (!rEnv[ch][3] && mVol[ch] > 0)
						mVol[ch]--;
				end else begin
					mEnvCnt[ch]--;
				end
			end
		end
	endtask

	// One write mirrored into the model
	task automatic writeModel(input regAddrT addr, input regDataT data);
		int ch;
		int field;
		wrEnable = 1'b1;
		wrAddr   = addr;
		wrData   = data;
		step();
		wrEnable = 1'b0;
		ch    = int'(addr) / 4;
		field = int'(addr) % 4;
		for (int c = 0; c < 2; c++)
			advance(c, cyc);
		quietUntil = cyc + 4;
		if (addr == AddrMaster)
			rMaster = data[2:0];
		else if (addr == AddrEnable)
			rMask = data[1:0];
		else if (ch < 2) begin
			case (field)
				0: rDutyLen[ch] = data;
				1: rEnv[ch] = data;
				2: rFreq[ch][7:0] = data;
				default: begin
					rFreq[ch][10:8] = data[2:0];
					rTimed[ch]      = data[6];
					if (data[7])
						startChannel(ch, cyc + 1);   // Pulse lands one edge later
				end
			endcase
		end
	endtask

	////////////////////
	// Compare sample and active against the model
	task automatic checkPoint();
		int e;
		int lv;
		int sum;
		int expSample;
		logic safe;
		e    = cyc - 2;   // Level and mixer registers delay the sample
		sum  = 0;
		safe = (cyc >= quietUntil) && (e % FrameDivide >= Margin)
			&& (e % FrameDivide < FrameDivide - Margin);
		for (int ch = 0; ch < 2; ch++) begin
			advance(ch, e);
			if (mActive[ch] && ((e - mStepStart[ch] < Margin)
				|| (mStepStart[ch] + mStepLen[ch] - e < Margin)))
				safe = 1'b0;   // Near a duty step edge
			if (!mActive[ch])
				lv = 15;
			else if (patternHigh(rDutyLen[ch][7:6], mStep[ch]))
				lv = 15 + mVol[ch];
			else
				lv = 15 - mVol[ch];
			if (rMask[ch])
				sum += lv;
		end
		if (safe) begin
			expSample = (sum * (int'(rMaster) + 1)) / 8;
			checks++;
			assert (sample === sampleT'(expSample)) else begin
				errors++;
				$display("[FAIL] sample at cycle %0d: got %h, expected %h", cyc, sample,
					sampleT'(expSample));
			end
			assert (active1 === mActive[0]) else begin
				errors++;
				$display("[FAIL] active1 at cycle %0d: got %h, expected %h", cyc, active1,
					mActive[0]);
			end
			assert (active2 === mActive[1]) else begin
				errors++;
				$display("[FAIL] active2 at cycle %0d: got %h, expected %h", cyc, active2,
					mActive[1]);
			end
		end
	endtask

	task automatic runRow(input rowT row, input int idx);
		while (cyc % FrameDivide != 256)
			step();   // Start well clear of a frame step
		rowStart = cyc;
		writeModel(AddrMaster, {5'b0, row.master});
		writeModel(AddrEnable, {6'b0, row.mask});
		writeModel(AddrDuty1, row.dutyLen1);
		writeModel(AddrEnv1, row.env1);
		writeModel(AddrFreqLo1, row.freq1[7:0]);
		writeModel(AddrFreqHi1, {1'b1, row.timed1, 3'b000, row.freq1[10:8]});
		writeModel(AddrDuty2, row.dutyLen2);
		writeModel(AddrEnv2, row.env2);
		writeModel(AddrFreqLo2, row.freq2[7:0]);
		writeModel(AddrFreqHi2, {1'b1, row.timed2, 3'b000, row.freq2[10:8]});
		while (cyc - rowStart < row.cycles) begin
			if ((row.evAt != 0) && (cyc - rowStart == row.evAt))
				writeModel(AddrFreqHi1, row.evCtrl);   // Retrigger or frequency only
			else
				step();
			if ((cyc - rowStart) % 16 == 0)
				checkPoint();
		end
		assert ((active1 === row.expAct1) && (active2 === row.expAct2)) else begin
			errors++;
			$display("[FAIL] active1/active2 at end of row %0d: got %h/%h, expected %h/%h",
				idx, active1, active2, row.expAct1, row.expAct2);
		end
	endtask

	////////////////////
	// Watchdog from the total row length
	initial begin
		longint limit;
		#1;
		limit = 64'd30000 + 64'(NumRows) * FrameDivide;
		for (int i = 0; i < NumRows; i++)
			limit += 64'(rows[i].cycles);
		limit += 64'd32 * 64'd280;   // Mixer sweep
		#(limit * 100);
		$display("Watchdog expired after %0d cycles", limit);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		// Four duty rows at f 2016 then length, envelope, retrigger and frequency-only rows
		rows[0] = '{8'h00, 8'hA0, 11'd2016, 1'b0, 8'h00, 8'h00, 11'd2016, 1'b0,
			2'b01, 3'd7, 2100, 0, 8'h00, 1'b1, 1'b1};
		rows[1] = '{8'h40, 8'hA0, 11'd2016, 1'b0, 8'h00, 8'h00, 11'd2016, 1'b0,
			2'b01, 3'd7, 2100, 0, 8'h00, 1'b1, 1'b1};
		rows[2] = '{8'h80, 8'hA0, 11'd2016, 1'b0, 8'h00, 8'h00, 11'd2016, 1'b0,
			2'b01, 3'd7, 2100, 0, 8'h00, 1'b1, 1'b1};
		rows[3] = '{8'hC0, 8'hA0, 11'd2016, 1'b0, 8'h00, 8'h00, 11'd2016, 1'b0,
			2'b01, 3'd7, 2100, 0, 8'h00, 1'b1, 1'b1};
		rows[4] = '{8'hBE, 8'h80, 11'd2016, 1'b1, 8'h7E, 8'h60, 11'd1900, 1'b0,
			2'b11, 3'd3, 40000, 0, 8'h00, 1'b0, 1'b1};
		rows[5] = '{8'h80, 8'hD9, 11'd2016, 1'b0, 8'h40, 8'h21, 11'd1984, 1'b0,
			2'b11, 3'd7, 210000, 0, 8'h00, 1'b1, 1'b1};
		// Retrigger lands after an envelope step, so the reloaded volume shows
		rows[6] = '{8'hBC, 8'h91, 11'd2016, 1'b1, 8'hBC, 8'h91, 11'd2016, 1'b1,
			2'b11, 3'd7, 70000, 36000, 8'hC7, 1'b1, 1'b0};
		rows[7] = '{8'hBE, 8'h91, 11'd2016, 1'b1, 8'hBE, 8'h91, 11'd2016, 1'b1,
			2'b11, 3'd5, 34000, 20000, 8'h45, 1'b0, 1'b0};
		errors     = 0;
		checks     = 0;
		quietUntil = 0;
		rMask      = '0;
		rMaster    = '0;
		for (int ch = 0; ch < 2; ch++) begin
			rDutyLen[ch]   = '0;
			rEnv[ch]       = '0;
			rFreq[ch]      = '0;
			rTimed[ch]     = 1'b0;
			mActive[ch]    = 1'b0;
			mStep[ch]      = 0;
			mStepStart[ch] = 0;
			mStepLen[ch]   = 1000000000;   // Idle until the first trigger
			mLastK[ch]     = 0;
		end
		wrEnable = 1'b0;
		wrAddr   = '0;
		wrData   = '0;
		arstN    = 1'b0;
		repeat (2) @(posedge iClock);
		#10;
		arstN = 1'b1;

		// Silent and idle before any trigger
		repeat (200) begin
			step();
			checks++;
			assert ((sample === '0) && (active1 === 1'b0) && (active2 === 1'b0)) else begin
				errors++;
				$display("[FAIL] sample/active1/active2 after reset: got %h/%h/%h, %s",
					sample, active1, active2, "expected 000/0/0");
			end
		end

		for (int i = 0; i < NumRows; i++)
			runRow(rows[i], i);

		////////////////////
		// Mixer sweep over all masks and master volumes
		writeModel(AddrDuty1, 8'h80);
		writeModel(AddrEnv1, 8'hB0);
		writeModel(AddrFreqLo1, 8'hE0);
		writeModel(AddrFreqHi1, 8'h87);   // f 2016 untimed
		writeModel(AddrDuty2, 8'h40);
		writeModel(AddrEnv2, 8'h70);
		writeModel(AddrFreqLo2, 8'h6C);
		writeModel(AddrFreqHi2, 8'h87);   // f 1900
		for (int m = 0; m < 4; m++) begin
			for (int v = 0; v < 8; v++) begin
				writeModel(AddrMaster, regDataT'(v));
				writeModel(AddrEnable, regDataT'(m));
				repeat (256) begin
					step();
					if (cyc % 16 == 0)
						checkPoint();
				end
			end
		end

		errors += u_soundCtrl.asserts.failCount;   // Bound checker failures
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
design/soundPkg.sv
design/frameSequencer.sv
design/soundRegisters.sv
design/squareChannel.sv
design/soundMixer.sv
design/soundCtrl.sv
testbench/soundCtrl_asserts.sv
testbench/soundCtrlTb.sv

// ==== Makefile ====
# Verilator simulation of the sound controller

VERILATOR ?= verilator
TOP       ?= soundCtrlTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" $(LOG) || \
		! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
